// File: all.f
common/cipher_ctrl_pkg.sv
rtl/sparse_sig_guard.sv
rtl/rail_combiner.sv
fsm/cipher_round_fsm.sv
rtl/cipher_ctrl_top.sv
verification/cipher_ctrl_chk.sv
verification/tb_cipher_ctrl.sv

// File: common/cipher_ctrl_pkg.sv
package cipher_ctrl_pkg;

  ////////////////////////////////////////
  // Sparse boolean and rails
  ////////////////////////////////////////

  localparam int Sp2VWidth = 3; // One FSM rail per bit

  // Legal values are complementary, every other pattern is a fault
  typedef enum logic [Sp2VWidth-1:0] {
    SP2V_HIGH = 3'b011,
    SP2V_LOW  = 3'b100
  } sp2v_e;

  // Set bits mark positive rails, cleared bits mark inverted rails
  localparam logic [Sp2VWidth-1:0] RailPositive = SP2V_HIGH;

  // Guarded sparse inputs: in_valid, out_ready and sub_bytes_out_req
  localparam int NumSparseIn = 3;

  ////////////////////////////////////////
  // Operation and key length
  ////////////////////////////////////////

  typedef enum logic {
    CIPH_FWD = 1'b0,
    CIPH_INV = 1'b1
  } ciph_op_e;

  typedef enum logic [2:0] {
    AES_128 = 3'b001,
    AES_192 = 3'b010,
    AES_256 = 3'b100
  } key_len_e;

  localparam int RndCtrWidth = 4;

  // Last round per key length
  localparam logic [RndCtrWidth-1:0] NumRounds128 = 4'd10;
  localparam logic [RndCtrWidth-1:0] NumRounds192 = 4'd12;
  localparam logic [RndCtrWidth-1:0] NumRounds256 = 4'd14;

  ////////////////////////////////////////
  // Datapath selectors
  ////////////////////////////////////////

  localparam int StateSelWidth = 3;
  localparam int AddRkSelWidth = 3;

  // State register input mux
  typedef enum logic [StateSelWidth-1:0] {
    STATE_INIT  = 3'b100,
    STATE_ROUND = 3'b010,
    STATE_CLEAR = 3'b001
  } state_sel_e;

  // AddRoundKey input mux
  typedef enum logic [AddRkSelWidth-1:0] {
    ADD_RK_INIT  = 3'b100,
    ADD_RK_ROUND = 3'b010,
    ADD_RK_FINAL = 3'b001
  } add_rk_sel_e;

  ////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////

  // Shared by every rail, ERROR is terminal until reset
  typedef enum logic [2:0] {
    IDLE   = 3'b000,
    INIT   = 3'b011,
    ROUND  = 3'b101,
    FINISH = 3'b110,
    ERROR  = 3'b111
  } ctrl_state_e;

endpackage

// File: fsm/cipher_round_fsm.sv
module cipher_round_fsm #(
  parameter bit RailInverted = 1'b0 // Rail handshake bits use inverted logic
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,

  // Block handshake, rail bits
  input  logic                                    in_valid_i,
  output logic                                    in_ready_o,
  output logic                                    out_valid_o,
  input  logic                                    out_ready_i,

  // Block configuration
  input  cipher_ctrl_pkg::ciph_op_e               op_i,
  input  cipher_ctrl_pkg::key_len_e               key_len_i,

  // Fault inputs and alert
  input  logic                                    enc_err_i,
  input  logic                                    mismatch_i,
  output logic                                    alert_o,

  // Cipher datapath
  output cipher_ctrl_pkg::state_sel_e             state_sel_o,
  output logic                                    state_we_o,
  output logic                                    sub_bytes_en_o,
  input  logic                                    sub_bytes_out_req_i,
  output logic                                    sub_bytes_out_ack_o,
  output cipher_ctrl_pkg::add_rk_sel_e            add_rk_sel_o,

  // Key expansion
  output logic                                    key_expand_en_o,
  output cipher_ctrl_pkg::ciph_op_e               op_o,
  output logic [cipher_ctrl_pkg::RndCtrWidth-1:0] rnd_ctr_o
);

  cipher_ctrl_pkg::ctrl_state_e             state_d, state_q;
  cipher_ctrl_pkg::ciph_op_e                op_d, op_q;
  cipher_ctrl_pkg::key_len_e                key_len_d, key_len_q;
  logic [cipher_ctrl_pkg::RndCtrWidth-1:0]  rnd_ctr_d, rnd_ctr_q;
  logic [cipher_ctrl_pkg::RndCtrWidth-1:0]  last_rnd;
  logic                                     last_rnd_hit;

  // Positive logic copies of the rail bits
  logic in_valid, out_ready, sub_bytes_out_req;
  logic in_ready, out_valid, sub_bytes_en, sub_bytes_out_ack;
  logic state_we, key_expand_en;

  ////////////////////////////////////////
  // Rail polarity
  ////////////////////////////////////////

  assign in_valid          = in_valid_i ^ RailInverted;
  assign out_ready         = out_ready_i ^ RailInverted;
  assign sub_bytes_out_req = sub_bytes_out_req_i ^ RailInverted;

  assign in_ready_o          = in_ready ^ RailInverted;
  assign out_valid_o         = out_valid ^ RailInverted;
  assign sub_bytes_en_o      = sub_bytes_en ^ RailInverted;
  assign sub_bytes_out_ack_o = sub_bytes_out_ack ^ RailInverted;
  assign state_we_o          = state_we ^ RailInverted;
  assign key_expand_en_o     = key_expand_en ^ RailInverted;

  ////////////////////////////////////////
  // Round limit
  ////////////////////////////////////////

  always_comb begin : round_limit
    case (key_len_q)
      cipher_ctrl_pkg::AES_192: last_rnd = cipher_ctrl_pkg::NumRounds192;
      cipher_ctrl_pkg::AES_256: last_rnd = cipher_ctrl_pkg::NumRounds256;
      default:                  last_rnd = cipher_ctrl_pkg::NumRounds128;
    endcase
  end

  assign last_rnd_hit = (rnd_ctr_q == last_rnd);

  ////////////////////////////////////////
  // Next state and outputs
  ////////////////////////////////////////

  always_comb begin : fsm_comb
    state_d   = state_q;
    op_d      = op_q;
    key_len_d = key_len_q;
    rnd_ctr_d = rnd_ctr_q;

    in_ready          = 1'b0;
    out_valid         = 1'b0;
    sub_bytes_en      = 1'b0;
    sub_bytes_out_ack = 1'b0;
    state_we          = 1'b0;
    key_expand_en     = 1'b0;
    state_sel_o       = cipher_ctrl_pkg::STATE_ROUND;
    add_rk_sel_o      = cipher_ctrl_pkg::ADD_RK_ROUND;
    alert_o           = 1'b0;

    case (state_q)
      cipher_ctrl_pkg::IDLE: begin
        in_ready = 1'b1;
        if (in_valid) begin
          op_d      = op_i; // Key expansion follows the block operation
          key_len_d = key_len_i;
          rnd_ctr_d = '0;
          state_d   = cipher_ctrl_pkg::INIT;
        end
      end

      // Initial AddRoundKey with round key 0
      cipher_ctrl_pkg::INIT: begin
        state_we     = 1'b1;
        state_sel_o  = cipher_ctrl_pkg::STATE_INIT;
        add_rk_sel_o = cipher_ctrl_pkg::ADD_RK_INIT;
        rnd_ctr_d    = cipher_ctrl_pkg::RndCtrWidth'(1);
        state_d      = cipher_ctrl_pkg::ROUND;
      end

      cipher_ctrl_pkg::ROUND: begin
        sub_bytes_en = 1'b1;
        if (sub_bytes_out_req) begin // Round completes in this cycle
          sub_bytes_out_ack = 1'b1;
          state_we          = 1'b1;
          key_expand_en     = 1'b1;
          add_rk_sel_o      = last_rnd_hit ? cipher_ctrl_pkg::ADD_RK_FINAL
                                           : cipher_ctrl_pkg::ADD_RK_ROUND;
          rnd_ctr_d         = rnd_ctr_q + cipher_ctrl_pkg::RndCtrWidth'(1);
          if (last_rnd_hit) begin
            state_d = cipher_ctrl_pkg::FINISH;
          end
        end
      end

      cipher_ctrl_pkg::FINISH: begin
        out_valid = 1'b1; // Held until the result is taken
        if (out_ready) begin
          state_d = cipher_ctrl_pkg::IDLE;
        end
      end

      cipher_ctrl_pkg::ERROR: begin
        alert_o     = 1'b1;
        state_sel_o = cipher_ctrl_pkg::STATE_CLEAR;
      end

      default: state_d = cipher_ctrl_pkg::ERROR; // Corrupted state register
    endcase

    // Any fault wins over the regular transition
    if (enc_err_i || mismatch_i) begin
      state_d = cipher_ctrl_pkg::ERROR;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : fsm_regs
    if (!rst_ni) begin
      state_q   <= cipher_ctrl_pkg::IDLE;
      op_q      <= cipher_ctrl_pkg::CIPH_FWD;
      key_len_q <= cipher_ctrl_pkg::AES_128;
      rnd_ctr_q <= '0;
    end else begin
      state_q   <= state_d;
      op_q      <= op_d;
      key_len_q <= key_len_d;
      rnd_ctr_q <= rnd_ctr_d;
    end
  end

  assign op_o      = op_q;
  assign rnd_ctr_o = rnd_ctr_q;

endmodule

// File: rtl/cipher_ctrl_top.sv
module cipher_ctrl_top (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,

  // Block handshake
  input  cipher_ctrl_pkg::sp2v_e                  in_valid_i,
  output cipher_ctrl_pkg::sp2v_e                  in_ready_o,
  output cipher_ctrl_pkg::sp2v_e                  out_valid_o,
  input  cipher_ctrl_pkg::sp2v_e                  out_ready_i,

  input  cipher_ctrl_pkg::ciph_op_e               op_i,
  input  cipher_ctrl_pkg::key_len_e               key_len_i,

  // Cipher datapath
  output cipher_ctrl_pkg::sp2v_e                  sub_bytes_en_o,
  input  cipher_ctrl_pkg::sp2v_e                  sub_bytes_out_req_i,
  output cipher_ctrl_pkg::sp2v_e                  sub_bytes_out_ack_o,
  output cipher_ctrl_pkg::sp2v_e                  state_we_o,
  output cipher_ctrl_pkg::state_sel_e             state_sel_o,
  output cipher_ctrl_pkg::add_rk_sel_e            add_rk_sel_o,

  // Key expansion
  output cipher_ctrl_pkg::sp2v_e                  key_expand_en_o,
  output cipher_ctrl_pkg::ciph_op_e               key_expand_op_o,
  output logic [cipher_ctrl_pkg::RndCtrWidth-1:0] key_expand_round_o,

  output logic                                    alert_o
);

  cipher_ctrl_pkg::sp2v_e [cipher_ctrl_pkg::NumSparseIn-1:0] sp_sig;
  logic [cipher_ctrl_pkg::NumSparseIn-1:0][cipher_ctrl_pkg::Sp2VWidth-1:0] sp_rail;
  logic enc_err;
  logic mismatch;

  // Rail bits of the sparse outputs
  logic [cipher_ctrl_pkg::Sp2VWidth-1:0] sp_in_ready, sp_out_valid;
  logic [cipher_ctrl_pkg::Sp2VWidth-1:0] sp_sub_bytes_en, sp_sub_bytes_out_ack;
  logic [cipher_ctrl_pkg::Sp2VWidth-1:0] sp_state_we, sp_key_expand_en;

  // Full per-rail copies
  cipher_ctrl_pkg::state_sel_e  [cipher_ctrl_pkg::Sp2VWidth-1:0] mr_state_sel;
  cipher_ctrl_pkg::add_rk_sel_e [cipher_ctrl_pkg::Sp2VWidth-1:0] mr_add_rk_sel;
  cipher_ctrl_pkg::ciph_op_e    [cipher_ctrl_pkg::Sp2VWidth-1:0] mr_op;
  logic [cipher_ctrl_pkg::Sp2VWidth-1:0][cipher_ctrl_pkg::RndCtrWidth-1:0] mr_rnd_ctr;
  logic [cipher_ctrl_pkg::Sp2VWidth-1:0] mr_alert;

  assign sp_sig[0] = in_valid_i;
  assign sp_sig[1] = out_ready_i;
  assign sp_sig[2] = sub_bytes_out_req_i;

  sparse_sig_guard #(
    .NumSig ( cipher_ctrl_pkg::NumSparseIn )
  ) u_guard (
    .sig_i  ( sp_sig  ),
    .rail_o ( sp_rail ),
    .err_o  ( enc_err )
  );

  ////////////////////////////////////////
  // Redundant FSM rails
  ////////////////////////////////////////

  for (genvar i = 0; i < cipher_ctrl_pkg::Sp2VWidth; i++) begin : gen_rail
    cipher_round_fsm #(
      .RailInverted ( ~cipher_ctrl_pkg::RailPositive[i] )
    ) u_rail (
      .clk_i               ( clk_i                   ),
      .rst_ni              ( rst_ni                  ),
      .in_valid_i          ( sp_rail[0][i]           ),
      .in_ready_o          ( sp_in_ready[i]          ),
      .out_valid_o         ( sp_out_valid[i]         ),
      .out_ready_i         ( sp_rail[1][i]           ),
      .op_i                ( op_i                    ),
      .key_len_i           ( key_len_i               ),
      .enc_err_i           ( enc_err                 ),
      .mismatch_i          ( mismatch                ),
      .alert_o             ( mr_alert[i]             ),
      .state_sel_o         ( mr_state_sel[i]         ),
      .state_we_o          ( sp_state_we[i]          ),
      .sub_bytes_en_o      ( sp_sub_bytes_en[i]      ),
      .sub_bytes_out_req_i ( sp_rail[2][i]           ),
      .sub_bytes_out_ack_o ( sp_sub_bytes_out_ack[i] ),
      .add_rk_sel_o        ( mr_add_rk_sel[i]        ),
      .key_expand_en_o     ( sp_key_expand_en[i]     ),
      .op_o                ( mr_op[i]                ),
      .rnd_ctr_o           ( mr_rnd_ctr[i]           )
    );
  end

  rail_combiner u_combiner (
    .mr_in_ready_i          ( sp_in_ready          ),
    .mr_out_valid_i         ( sp_out_valid         ),
    .mr_sub_bytes_en_i      ( sp_sub_bytes_en      ),
    .mr_sub_bytes_out_ack_i ( sp_sub_bytes_out_ack ),
    .mr_state_we_i          ( sp_state_we          ),
    .mr_key_expand_en_i     ( sp_key_expand_en     ),
    .mr_state_sel_i         ( mr_state_sel         ),
    .mr_add_rk_sel_i        ( mr_add_rk_sel        ),
    .mr_op_i                ( mr_op                ),
    .mr_rnd_ctr_i           ( mr_rnd_ctr           ),
    .mr_alert_i             ( mr_alert             ),
    .in_ready_o             ( in_ready_o           ),
    .out_valid_o            ( out_valid_o          ),
    .sub_bytes_en_o         ( sub_bytes_en_o       ),
    .sub_bytes_out_ack_o    ( sub_bytes_out_ack_o  ),
    .state_we_o             ( state_we_o           ),
    .key_expand_en_o        ( key_expand_en_o      ),
    .state_sel_o            ( state_sel_o          ),
    .add_rk_sel_o           ( add_rk_sel_o         ),
    .key_expand_op_o        ( key_expand_op_o      ),
    .key_expand_round_o     ( key_expand_round_o   ),
    .alert_o                ( alert_o              ),
    .mismatch_o             ( mismatch             ) // Back to every rail
  );

endmodule

// File: rtl/rail_combiner.sv
module rail_combiner (
  // Sparse outputs, one bit per rail
  input  logic [cipher_ctrl_pkg::Sp2VWidth-1:0]         mr_in_ready_i,
  input  logic [cipher_ctrl_pkg::Sp2VWidth-1:0]         mr_out_valid_i,
  input  logic [cipher_ctrl_pkg::Sp2VWidth-1:0]         mr_sub_bytes_en_i,
  input  logic [cipher_ctrl_pkg::Sp2VWidth-1:0]         mr_sub_bytes_out_ack_i,
  input  logic [cipher_ctrl_pkg::Sp2VWidth-1:0]         mr_state_we_i,
  input  logic [cipher_ctrl_pkg::Sp2VWidth-1:0]         mr_key_expand_en_i,

  // Full copies, one per rail
  input  cipher_ctrl_pkg::state_sel_e  [cipher_ctrl_pkg::Sp2VWidth-1:0] mr_state_sel_i,
  input  cipher_ctrl_pkg::add_rk_sel_e [cipher_ctrl_pkg::Sp2VWidth-1:0] mr_add_rk_sel_i,
  input  cipher_ctrl_pkg::ciph_op_e    [cipher_ctrl_pkg::Sp2VWidth-1:0] mr_op_i,
  input  logic [cipher_ctrl_pkg::Sp2VWidth-1:0][cipher_ctrl_pkg::RndCtrWidth-1:0] mr_rnd_ctr_i,
  input  logic [cipher_ctrl_pkg::Sp2VWidth-1:0]         mr_alert_i,

  output cipher_ctrl_pkg::sp2v_e                        in_ready_o,
  output cipher_ctrl_pkg::sp2v_e                        out_valid_o,
  output cipher_ctrl_pkg::sp2v_e                        sub_bytes_en_o,
  output cipher_ctrl_pkg::sp2v_e                        sub_bytes_out_ack_o,
  output cipher_ctrl_pkg::sp2v_e                        state_we_o,
  output cipher_ctrl_pkg::sp2v_e                        key_expand_en_o,
  output cipher_ctrl_pkg::state_sel_e                   state_sel_o,
  output cipher_ctrl_pkg::add_rk_sel_e                  add_rk_sel_o,
  output cipher_ctrl_pkg::ciph_op_e                     key_expand_op_o,
  output logic [cipher_ctrl_pkg::RndCtrWidth-1:0]       key_expand_round_o,
  output logic                                          alert_o,
  output logic                                          mismatch_o
);

  logic [cipher_ctrl_pkg::StateSelWidth-1:0] state_sel;
  logic [cipher_ctrl_pkg::AddRkSelWidth-1:0] add_rk_sel;
  logic                                      op;
  logic [cipher_ctrl_pkg::RndCtrWidth-1:0]   rnd_ctr;

  // Each rail contributes its own bit of every sparse word
  assign in_ready_o          = cipher_ctrl_pkg::sp2v_e'(mr_in_ready_i);
  assign out_valid_o         = cipher_ctrl_pkg::sp2v_e'(mr_out_valid_i);
  assign sub_bytes_en_o      = cipher_ctrl_pkg::sp2v_e'(mr_sub_bytes_en_i);
  assign sub_bytes_out_ack_o = cipher_ctrl_pkg::sp2v_e'(mr_sub_bytes_out_ack_i);
  assign state_we_o          = cipher_ctrl_pkg::sp2v_e'(mr_state_we_i);
  assign key_expand_en_o     = cipher_ctrl_pkg::sp2v_e'(mr_key_expand_en_i);

  // OR over all rails, then compare every rail against the result
  always_comb begin : combine_rails
    state_sel  = '0;
    add_rk_sel = '0;
    op         = 1'b0;
    rnd_ctr    = '0;
    mismatch_o = 1'b0;

    for (int i = 0; i < cipher_ctrl_pkg::Sp2VWidth; i++) begin
      state_sel  |= mr_state_sel_i[i];
      add_rk_sel |= mr_add_rk_sel_i[i];
      op         |= mr_op_i[i];
      rnd_ctr    |= mr_rnd_ctr_i[i];
    end

    for (int i = 0; i < cipher_ctrl_pkg::Sp2VWidth; i++) begin
      if (state_sel  != mr_state_sel_i[i]  ||
          add_rk_sel != mr_add_rk_sel_i[i] ||
          op         != mr_op_i[i]         ||
          rnd_ctr    != mr_rnd_ctr_i[i]) begin
        mismatch_o = 1'b1; // Divergent rail
      end
    end
  end

  assign state_sel_o        = cipher_ctrl_pkg::state_sel_e'(state_sel);
  assign add_rk_sel_o       = cipher_ctrl_pkg::add_rk_sel_e'(add_rk_sel);
  assign key_expand_op_o    = cipher_ctrl_pkg::ciph_op_e'(op);
  assign key_expand_round_o = rnd_ctr;
  assign alert_o            = |mr_alert_i; // A single rail is enough

endmodule

// File: rtl/sparse_sig_guard.sv
module sparse_sig_guard #(
  parameter int NumSig = 1
) (
  input  cipher_ctrl_pkg::sp2v_e [NumSig-1:0]                         sig_i,
  output logic [NumSig-1:0][cipher_ctrl_pkg::Sp2VWidth-1:0]          rail_o,
  output logic                                                        err_o
);

  logic [NumSig-1:0] sig_err; // Per signal encoding fault

  ////////////////////////////////////////
  // Encoding check
  ////////////////////////////////////////

  always_comb begin : check_sig
    for (int i = 0; i < NumSig; i++) begin
      // Only the two complementary words are legal
      sig_err[i] = (sig_i[i] != cipher_ctrl_pkg::SP2V_HIGH) &&
                   (sig_i[i] != cipher_ctrl_pkg::SP2V_LOW);
    end
  end

  assign err_o = |sig_err;

  ////////////////////////////////////////
  // Rail split
  ////////////////////////////////////////

  // Bit j of each word goes to rail j, polarity left as is
  always_comb begin : split_rails
    for (int i = 0; i < NumSig; i++) begin
      rail_o[i] = sig_i[i];
    end
  end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build with Verilator and run, exit status carries the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_cipher_ctrl -f all.f -Mdir obj_dir -o tb_cipher_ctrl \
  && ./obj_dir/tb_cipher_ctrl \
  || { echo "Simulation run did not complete successfully"; exit 1; }

// File: verification/cipher_ctrl_chk.sv
module cipher_ctrl_chk (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  cipher_ctrl_pkg::sp2v_e in_ready_o,
  input  cipher_ctrl_pkg::sp2v_e out_valid_o,
  input  logic                   alert_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // Sticky alert, only reset may clear it
  alert_sticky_a: assert property (@(posedge clk_i) $fell(alert_o) |-> !rst_ni)
    else $error("alert_o dropped while reset was not applied");

  no_valid_on_alert_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    alert_o |-> out_valid_o != cipher_ctrl_pkg::SP2V_HIGH)
    else $error("out_valid_o high while alert_o is set");

  legal_in_ready_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    in_ready_o inside {cipher_ctrl_pkg::SP2V_HIGH, cipher_ctrl_pkg::SP2V_LOW})
    else $error("in_ready_o holds an illegal encoding");

  legal_out_valid_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_valid_o inside {cipher_ctrl_pkg::SP2V_HIGH, cipher_ctrl_pkg::SP2V_LOW})
    else $error("out_valid_o holds an illegal encoding");

endmodule

bind cipher_ctrl_top cipher_ctrl_chk u_chk (
  .clk_i       ( clk_i       ),
  .rst_ni      ( rst_ni      ),
  .in_ready_o  ( in_ready_o  ),
  .out_valid_o ( out_valid_o ),
  .alert_o     ( alert_o     )
);

// File: verification/cipher_ctrl_patterns.txt
// op key_len(one-hot 1/2/4) rounds stall fault, all hex
// fault 1 drives an illegal in_valid_i in place of a block
0 1 a 0 0
1 1 a 3 0
0 2 c 0 0
1 2 c 5 0
0 4 e 1 0
1 4 e 8 0
0 1 a 2 0
0 0 0 0 1
1 4 e 0 0
0 2 c 4 0
1 1 a 6 0
0 4 e 2 0
0 0 0 0 1
1 2 c 1 0
0 1 a 7 0
1 4 e 3 0
0 2 c 2 0
0 0 0 0 1

// File: verification/tb_cipher_ctrl.sv
module tb_cipher_ctrl;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MaxTests  = 32;
  localparam int PatFields = 5; // op, key_len, rounds, stall, fault

  logic clk_i;
  logic rst_ni;
  cipher_ctrl_pkg::sp2v_e in_valid_i, in_ready_o, out_valid_o, out_ready_i;
  cipher_ctrl_pkg::sp2v_e sub_bytes_en_o, sub_bytes_out_req_i, sub_bytes_out_ack_o;
  cipher_ctrl_pkg::sp2v_e state_we_o, key_expand_en_o;
  cipher_ctrl_pkg::ciph_op_e op_i, key_expand_op_o;
  cipher_ctrl_pkg::key_len_e key_len_i;
  cipher_ctrl_pkg::state_sel_e state_sel_o;
  cipher_ctrl_pkg::add_rk_sel_e add_rk_sel_o;
  logic [cipher_ctrl_pkg::RndCtrWidth-1:0] key_expand_round_o;
  logic alert_o;

  logic [7:0] pat_mem [MaxTests*PatFields];
  int cycle_cnt;
  int cycle_limit = 0; // Set once the patterns are known

  cipher_ctrl_top UUT (
    .clk_i               ( clk_i               ),
    .rst_ni              ( rst_ni              ),
    .in_valid_i          ( in_valid_i          ),
    .in_ready_o          ( in_ready_o          ),
    .out_valid_o         ( out_valid_o         ),
    .out_ready_i         ( out_ready_i         ),
    .op_i                ( op_i                ),
    .key_len_i           ( key_len_i           ),
    .sub_bytes_en_o      ( sub_bytes_en_o      ),
    .sub_bytes_out_req_i ( sub_bytes_out_req_i ),
    .sub_bytes_out_ack_o ( sub_bytes_out_ack_o ),
    .state_we_o          ( state_we_o          ),
    .state_sel_o         ( state_sel_o         ),
    .add_rk_sel_o        ( add_rk_sel_o        ),
    .key_expand_en_o     ( key_expand_en_o     ),
    .key_expand_op_o     ( key_expand_op_o     ),
    .key_expand_round_o  ( key_expand_round_o  ),
    .alert_o             ( alert_o             )
  );

  ////////////////////////////////////////
  // Clock and timeout
  ////////////////////////////////////////

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  initial begin : timeout_watch
    cycle_cnt = 0;
    forever begin
      @(posedge clk_i);
      cycle_cnt++;
      if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
        $display("Timeout after %0d cycles, the DUT stopped making progress", cycle_cnt);
        $display("Verification failed");
        $fatal(1);
      end
    end
  end

  ////////////////////////////////////////
  // Timing and compare helpers
  ////////////////////////////////////////

  task automatic next_drive_slot();
    @(posedge clk_i);
    #10; // Inputs change here
  endtask

  task automatic sample_slot();
    @(negedge clk_i);
  endtask

  task automatic report_mismatch(input string name, input string exp_s, input string act_s);
    $display("[FAIL] %0t ns %s expected %s actual %s", $time, name, exp_s, act_s);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_sp2v(input string name, input cipher_ctrl_pkg::sp2v_e exp,
                            input cipher_ctrl_pkg::sp2v_e act);
    if (act !== exp) report_mismatch(name, $sformatf("%b", exp), $sformatf("%b", act));
  endtask

  task automatic check_state_sel(input cipher_ctrl_pkg::state_sel_e exp,
                                 input cipher_ctrl_pkg::state_sel_e act);
    if (act !== exp) report_mismatch("state_sel_o", $sformatf("%b", exp), $sformatf("%b", act));
  endtask

  task automatic check_add_rk_sel(input cipher_ctrl_pkg::add_rk_sel_e exp,
                                  input cipher_ctrl_pkg::add_rk_sel_e act);
    if (act !== exp) report_mismatch("add_rk_sel_o", $sformatf("%b", exp), $sformatf("%b", act));
  endtask

  task automatic check_op(input cipher_ctrl_pkg::ciph_op_e exp,
                          input cipher_ctrl_pkg::ciph_op_e act);
    if (act !== exp) report_mismatch("key_expand_op_o", $sformatf("%b", exp), $sformatf("%b", act));
  endtask

  task automatic check_round(input string name, input logic [cipher_ctrl_pkg::RndCtrWidth-1:0] exp,
                             input logic [cipher_ctrl_pkg::RndCtrWidth-1:0] act);
    if (act !== exp) report_mismatch(name, $sformatf("%0d", exp), $sformatf("%0d", act));
  endtask

  task automatic check_alert(input logic exp, input logic act);
    if (act !== exp) report_mismatch("alert_o", $sformatf("%b", exp), $sformatf("%b", act));
  endtask

  task automatic check_reset_values();
    check_sp2v("in_ready_o", cipher_ctrl_pkg::SP2V_HIGH, in_ready_o);
    check_sp2v("out_valid_o", cipher_ctrl_pkg::SP2V_LOW, out_valid_o);
    check_sp2v("sub_bytes_en_o", cipher_ctrl_pkg::SP2V_LOW, sub_bytes_en_o);
    check_sp2v("state_we_o", cipher_ctrl_pkg::SP2V_LOW, state_we_o);
    check_sp2v("key_expand_en_o", cipher_ctrl_pkg::SP2V_LOW, key_expand_en_o);
    check_alert(1'b0, alert_o);
  endtask

  task automatic apply_reset();
    rst_ni = 1'b0;
    repeat (10) next_drive_slot();
    rst_ni = 1'b1;
  endtask

  ////////////////////////////////////////
  // SubBytes datapath model
  ////////////////////////////////////////

  initial begin : sub_bytes_model
    int unsigned wait_cycles;
    sub_bytes_out_req_i = cipher_ctrl_pkg::SP2V_LOW;
    void'($urandom(47)); // One seed for the whole run
    forever begin
      next_drive_slot();
      sub_bytes_out_req_i = cipher_ctrl_pkg::SP2V_LOW;
      if (sub_bytes_en_o == cipher_ctrl_pkg::SP2V_HIGH) begin
        wait_cycles = $urandom % 4;
        repeat (wait_cycles) next_drive_slot();
        sub_bytes_out_req_i = cipher_ctrl_pkg::SP2V_HIGH;
        do begin
          sample_slot();
        end while (sub_bytes_out_ack_o != cipher_ctrl_pkg::SP2V_HIGH && !alert_o);
      end
    end
  end

  ////////////////////////////////////////
  // Test sequences
  ////////////////////////////////////////

  task automatic run_block(input cipher_ctrl_pkg::ciph_op_e op,
                           input cipher_ctrl_pkg::key_len_e key_len,
                           input logic [cipher_ctrl_pkg::RndCtrWidth-1:0] exp_rounds,
                           input int stall);
    logic [cipher_ctrl_pkg::RndCtrWidth-1:0] rounds;
    cipher_ctrl_pkg::add_rk_sel_e exp_rk;
    rounds = '0;
    next_drive_slot();
    in_valid_i = cipher_ctrl_pkg::SP2V_HIGH;
    op_i       = op;
    key_len_i  = key_len;
    sample_slot();
    check_sp2v("in_ready_o", cipher_ctrl_pkg::SP2V_HIGH, in_ready_o);
    next_drive_slot();
    // Inputs after the accepting edge must not reach the block
    in_valid_i = cipher_ctrl_pkg::SP2V_LOW;
    op_i       = cipher_ctrl_pkg::ciph_op_e'(~op);
    key_len_i  = (key_len == cipher_ctrl_pkg::AES_256) ? cipher_ctrl_pkg::AES_128
                                                       : cipher_ctrl_pkg::AES_256;
    sample_slot();
    check_sp2v("state_we_o", cipher_ctrl_pkg::SP2V_HIGH, state_we_o); // Initial key addition
    check_state_sel(cipher_ctrl_pkg::STATE_INIT, state_sel_o);
    check_add_rk_sel(cipher_ctrl_pkg::ADD_RK_INIT, add_rk_sel_o);
    check_round("key_expand_round_o", '0, key_expand_round_o);
    check_sp2v("in_ready_o", cipher_ctrl_pkg::SP2V_LOW, in_ready_o);
    check_sp2v("sub_bytes_en_o", cipher_ctrl_pkg::SP2V_LOW, sub_bytes_en_o);
    sample_slot();
    while (out_valid_o != cipher_ctrl_pkg::SP2V_HIGH) begin
      check_sp2v("in_ready_o", cipher_ctrl_pkg::SP2V_LOW, in_ready_o);
      check_sp2v("sub_bytes_en_o", cipher_ctrl_pkg::SP2V_HIGH, sub_bytes_en_o);
      if (sub_bytes_out_req_i == cipher_ctrl_pkg::SP2V_HIGH) begin
        rounds = rounds + 1'b1;
        exp_rk = (rounds == exp_rounds) ? cipher_ctrl_pkg::ADD_RK_FINAL
                                        : cipher_ctrl_pkg::ADD_RK_ROUND;
        check_sp2v("sub_bytes_out_ack_o", cipher_ctrl_pkg::SP2V_HIGH, sub_bytes_out_ack_o);
        check_sp2v("state_we_o", cipher_ctrl_pkg::SP2V_HIGH, state_we_o);
        check_sp2v("key_expand_en_o", cipher_ctrl_pkg::SP2V_HIGH, key_expand_en_o);
        check_state_sel(cipher_ctrl_pkg::STATE_ROUND, state_sel_o);
        check_add_rk_sel(exp_rk, add_rk_sel_o);
        check_round("key_expand_round_o", rounds, key_expand_round_o);
        check_op(op, key_expand_op_o);
      end else begin
        check_sp2v("sub_bytes_out_ack_o", cipher_ctrl_pkg::SP2V_LOW, sub_bytes_out_ack_o);
        check_sp2v("state_we_o", cipher_ctrl_pkg::SP2V_LOW, state_we_o); // Waiting on SubBytes
        check_sp2v("key_expand_en_o", cipher_ctrl_pkg::SP2V_LOW, key_expand_en_o);
      end
      sample_slot();
    end
    check_round("sub_bytes ack count", exp_rounds, rounds);
    check_sp2v("in_ready_o", cipher_ctrl_pkg::SP2V_LOW, in_ready_o);
    check_sp2v("sub_bytes_en_o", cipher_ctrl_pkg::SP2V_LOW, sub_bytes_en_o);
    // Extra stall cycles, result must hold
    repeat (stall) begin
      next_drive_slot();
      sample_slot();
      check_sp2v("out_valid_o", cipher_ctrl_pkg::SP2V_HIGH, out_valid_o);
      check_sp2v("in_ready_o", cipher_ctrl_pkg::SP2V_LOW, in_ready_o);
    end
    next_drive_slot();
    out_ready_i = cipher_ctrl_pkg::SP2V_HIGH;
    sample_slot();
    check_sp2v("out_valid_o", cipher_ctrl_pkg::SP2V_HIGH, out_valid_o);
    next_drive_slot();
    out_ready_i = cipher_ctrl_pkg::SP2V_LOW;
    sample_slot();
    check_sp2v("out_valid_o", cipher_ctrl_pkg::SP2V_LOW, out_valid_o);
    check_sp2v("in_ready_o", cipher_ctrl_pkg::SP2V_HIGH, in_ready_o);
    check_alert(1'b0, alert_o);
  endtask

  task automatic run_fault();
    next_drive_slot();
    in_valid_i = cipher_ctrl_pkg::sp2v_e'(3'b000); // Neither legal word
    sample_slot();
    check_alert(1'b0, alert_o);
    next_drive_slot();
    in_valid_i = cipher_ctrl_pkg::SP2V_HIGH; // A request the ERROR state must ignore
    sample_slot();
    repeat (4) begin
      check_alert(1'b1, alert_o);
      check_sp2v("out_valid_o", cipher_ctrl_pkg::SP2V_LOW, out_valid_o);
      check_sp2v("in_ready_o", cipher_ctrl_pkg::SP2V_LOW, in_ready_o);
      next_drive_slot();
      sample_slot();
    end
    next_drive_slot();
    in_valid_i = cipher_ctrl_pkg::SP2V_LOW;
    apply_reset();
    sample_slot();
    check_reset_values();
  endtask

  initial begin : run_tests
    int num_tests;
    int max_stall;
    num_tests = 0;
    max_stall = 0;
    for (int i = 0; i < MaxTests * PatFields; i++) begin
      pat_mem[i] = 8'hff; // End marker
    end
    $readmemh("verification/cipher_ctrl_patterns.txt", pat_mem);
    while (num_tests < MaxTests && pat_mem[num_tests*PatFields] != 8'hff) begin
      if (int'(pat_mem[num_tests*PatFields+3]) > max_stall) begin
        max_stall = int'(pat_mem[num_tests*PatFields+3]);
      end
      num_tests++;
    end
    cycle_limit = num_tests * (int'(cipher_ctrl_pkg::NumRounds256) * 6 + max_stall + 20);

    in_valid_i  = cipher_ctrl_pkg::SP2V_LOW;
    out_ready_i = cipher_ctrl_pkg::SP2V_LOW;
    op_i        = cipher_ctrl_pkg::CIPH_FWD;
    key_len_i   = cipher_ctrl_pkg::AES_128;
    apply_reset();
    sample_slot();
    check_reset_values();

    for (int t = 0; t < num_tests; t++) begin
      if (pat_mem[t*PatFields+4] != 8'h00) begin
        run_fault();
      end else begin
        run_block(cipher_ctrl_pkg::ciph_op_e'(pat_mem[t*PatFields][0]),
                  cipher_ctrl_pkg::key_len_e'(pat_mem[t*PatFields+1][2:0]),
                  pat_mem[t*PatFields+2][3:0],
                  int'(pat_mem[t*PatFields+3]));
      end
    end

    if (num_tests == 0) begin
      $display("No test vectors could be read from the pattern file");
      $display("Verification failed");
      $fatal(1);
    end else begin
      $display("Verification passed");
      $finish;
    end
  end

endmodule
